// File: rtl/power_pkg.sv
package power_pkg;

    // ##############################
    // Input word layout
    // ##############################

    // Samples arriving together in one input word.
    localparam int lanes = 8;

    // log2 of the lane count, used to divide the averaged sum by the lane count.
    localparam int lanes_log2 = 3;

    // Unsigned bits per sample.
    localparam int sample_width = 8;

    // ##############################
    // Datapath widths
    // ##############################

    // A square needs twice the sample width.
    localparam int square_width = 2 * sample_width;

    // Each level of the adder tree halves the node count and adds one bit.
    localparam int tree_levels = lanes_log2;

    // Eight full-scale squares need three bits more than one square.
    localparam int lane_sum_width = square_width + tree_levels;

    // The mean square per sample never exceeds one full-scale square.
    localparam int power_width = square_width;

    // ##############################
    // Pipeline timing
    // ##############################

    // Input register plus product register.
    localparam int square_latency = 2;

    // Cycles from an accepted word to the normalizer input, which is also
    // the depth of the round mode delay line in the top level.
    localparam int mode_delay = square_latency + tree_levels + 1;

    typedef logic [sample_width-1:0]   sample_t;
    typedef logic [square_width-1:0]   square_t;
    typedef logic [lane_sum_width-1:0] lane_sum_t;
    typedef logic [power_width-1:0]    power_t;

endpackage

// File: rtl/average_pkg.sv
package average_pkg;

    // ##############################
    // Moving average window
    // ##############################

    // Lane sums held in the averaging window.
    localparam int window_len = 16;

    // Shift that divides the running total by the window length.
    localparam int window_log2 = 4;

    // ##############################
    // Enumerations
    // ##############################

    // How the final division by the lane count treats the dropped bits.
    typedef enum logic {
        ROUND_TRUNCATE = 1'b0,
        ROUND_NEAREST  = 1'b1
    } round_mode_e;

    // The averager stays in FILLING until a whole window of real sums is in.
    typedef enum logic {
        FILLING = 1'b0,
        FULL    = 1'b1
    } fill_state_e;

endpackage

// File: rtl/square_lanes.sv
`timescale 1ns/1ns

module square_lanes (
    input  logic                                      clk,
    input  logic                                      rst,
    input  power_pkg::sample_t [power_pkg::lanes-1:0] samples,
    input  logic                                      in_valid,
    output power_pkg::square_t [power_pkg::lanes-1:0] squares,
    output logic                                      squares_valid
);

    // First stage holds the raw word so the multipliers start from a register.
    power_pkg::sample_t [power_pkg::lanes-1:0] sample_q;
    logic                                      sample_valid_q;

    // ##############################
    // Input register
    // ##############################

    always_ff @(posedge clk) begin
        sample_q <= samples;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid_q <= 1'b0;
        end else begin
            sample_valid_q <= in_valid;
        end
    end

    // ##############################
    // Product register
    // ##############################

    // Every lane gets its own multiplier; the operands are widened first so
    // the product keeps all sixteen bits.
    always_ff @(posedge clk) begin
        for (int i = 0; i < power_pkg::lanes; i++) begin
            squares[i] <= power_pkg::square_t'(sample_q[i]) *
                          power_pkg::square_t'(sample_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            squares_valid <= 1'b0;
        end else begin
            squares_valid <= sample_valid_q;
        end
    end

endmodule

// File: rtl/adder_tree.sv
`timescale 1ns/1ns

module adder_tree (
    input  logic                                      clk,
    input  logic                                      rst,
    input  power_pkg::square_t [power_pkg::lanes-1:0] squares,
    input  logic                                      squares_valid,
    output power_pkg::lane_sum_t                      lane_sum,
    output logic                                      lane_sum_valid
);

    // The tree is stored heap style. Node 1 is the root, node i has children
    // 2i and 2i+1, and indices from lanes upward would be the squares
    // themselves. Nodes lanes/2 to lanes-1 form the first level, the root
    // the last one. A node at level k only needs square_width + k bits, the
    // root all of lane_sum_width; the unused upper bits of the lower levels
    // stay zero.
    power_pkg::lane_sum_t node [1:power_pkg::lanes-1];

    // One valid bit per tree level.
    logic [power_pkg::tree_levels-1:0] valid_q;

    // ##############################
    // Tree nodes
    // ##############################

    for (genvar i = 1; i < power_pkg::lanes; i++) begin : g_node
        if (2 * i >= power_pkg::lanes) begin : g_first_level
            // Children are two neighbouring squares.
            always_ff @(posedge clk) begin
                node[i] <= power_pkg::lane_sum_t'(squares[2*i-power_pkg::lanes]) +
                           power_pkg::lane_sum_t'(squares[2*i+1-power_pkg::lanes]);
            end
        end else begin : g_upper_level
            always_ff @(posedge clk) begin
                node[i] <= node[2*i] + node[2*i+1];
            end
        end
    end

    // ##############################
    // Valid chain
    // ##############################

    // Valid moves one level per cycle, so a new word can enter every cycle
    // while earlier words are still climbing the tree.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[power_pkg::tree_levels-2:0], squares_valid};
        end
    end

    assign lane_sum       = node[1];
    assign lane_sum_valid = valid_q[power_pkg::tree_levels-1];

endmodule

// File: rtl/moving_average.sv
`timescale 1ns/1ns

module moving_average (
    input  logic                 clk,
    input  logic                 rst,
    input  power_pkg::lane_sum_t lane_sum,
    input  logic                 lane_sum_valid,
    output power_pkg::lane_sum_t mean_sum,
    output logic                 mean_valid
);

    // The running total grows by window_log2 bits over one lane sum.
    typedef logic [power_pkg::lane_sum_width+average_pkg::window_log2-1:0] total_t;
    typedef logic [average_pkg::window_log2-1:0] count_t;

    // Entry 0 holds the newest sum, the last entry the one to be dropped.
    power_pkg::lane_sum_t delay_line [average_pkg::window_len];

    total_t                   running_sum;
    count_t                   fill_count;
    average_pkg::fill_state_e fill_state;
    logic                     window_done;

    // ##############################
    // Delay line and running total
    // ##############################

    // The window only moves on valid sums, so bubbles leave it untouched.
    // Because the delay line starts at zero, the oldest entry subtracts
    // nothing while the window is still filling.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < average_pkg::window_len; i++) begin
                delay_line[i] <= '0;
            end
            running_sum <= '0;
        end else if (lane_sum_valid) begin
            delay_line[0] <= lane_sum;
            for (int i = 1; i < average_pkg::window_len; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
            running_sum <= running_sum + total_t'(lane_sum) -
                           total_t'(delay_line[average_pkg::window_len-1]);
        end
    end

    // Dividing by the window length is a plain shift and truncates.
    assign mean_sum = power_pkg::lane_sum_t'(running_sum >> average_pkg::window_log2);

    // ##############################
    // Warm-up control
    // ##############################

    // High for the sum that completes the first full window.
    assign window_done = (fill_count == count_t'(average_pkg::window_len - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state <= average_pkg::FILLING;
            fill_count <= '0;
            mean_valid <= 1'b0;
        end else begin
            mean_valid <= lane_sum_valid &&
                          (fill_state == average_pkg::FULL || window_done);
            if (lane_sum_valid && fill_state == average_pkg::FILLING) begin
                fill_count <= fill_count + 1'b1;
                if (window_done) begin
                    fill_state <= average_pkg::FULL;
                end
            end
        end
    end

endmodule

// File: rtl/power_normalize.sv
`timescale 1ns/1ns

module power_normalize (
    input  logic                     clk,
    input  logic                     rst,
    input  power_pkg::lane_sum_t     mean_sum,
    input  logic                     mean_valid,
    input  average_pkg::round_mode_e round_mode,
    output power_pkg::power_t        power,
    output logic                     power_valid
);

    power_pkg::power_t              quotient;
    logic [power_pkg::lanes_log2-1:0] remainder;
    logic                           round_up;

    // Dropping the low bits divides by the lane count.
    assign quotient  = power_pkg::power_t'(mean_sum >> power_pkg::lanes_log2);
    assign remainder = mean_sum[power_pkg::lanes_log2-1:0];

    // The top remainder bit is set when the dropped part is half or more,
    // so halves round up.
    assign round_up = (round_mode == average_pkg::ROUND_NEAREST) &&
                      remainder[power_pkg::lanes_log2-1];

    // A full-scale mean divides exactly, so the increment never carries out.
    always_ff @(posedge clk) begin
        if (mean_valid) begin
            power <= quotient + power_pkg::power_t'(round_up);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            power_valid <= 1'b0;
        end else begin
            power_valid <= mean_valid;
        end
    end

endmodule

// File: rtl/avg_power_top.sv
`timescale 1ns/1ns

module avg_power_top (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [power_pkg::lanes*power_pkg::sample_width-1:0] samples,
    input  logic                                                 in_valid,
    input  logic                                                 round_mode,
    output logic [power_pkg::power_width-1:0]                    power,
    output logic                                                 power_valid
);

    power_pkg::square_t [power_pkg::lanes-1:0] squares;
    logic                                      squares_valid;
    power_pkg::lane_sum_t                      lane_sum;
    logic                                      lane_sum_valid;
    power_pkg::lane_sum_t                      mean_sum;
    logic                                      mean_valid;

    // Round mode of each word, delayed to arrive with that word's mean.
    average_pkg::round_mode_e mode_pipe [power_pkg::mode_delay];

    // ##############################
    // Round mode alignment
    // ##############################

    always_ff @(posedge clk) begin
        mode_pipe[0] <= average_pkg::round_mode_e'(round_mode);
        for (int i = 1; i < power_pkg::mode_delay; i++) begin
            mode_pipe[i] <= mode_pipe[i-1];
        end
    end

    // ##############################
    // Datapath stages
    // ##############################

    square_lanes u_square_lanes (
        .clk           (clk),
        .rst           (rst),
        .samples       (samples),
        .in_valid      (in_valid),
        .squares       (squares),
        .squares_valid (squares_valid)
    );

    adder_tree u_adder_tree (
        .clk            (clk),
        .rst            (rst),
        .squares        (squares),
        .squares_valid  (squares_valid),
        .lane_sum       (lane_sum),
        .lane_sum_valid (lane_sum_valid)
    );

    moving_average u_moving_average (
        .clk            (clk),
        .rst            (rst),
        .lane_sum       (lane_sum),
        .lane_sum_valid (lane_sum_valid),
        .mean_sum       (mean_sum),
        .mean_valid     (mean_valid)
    );

    power_normalize u_power_normalize (
        .clk         (clk),
        .rst         (rst),
        .mean_sum    (mean_sum),
        .mean_valid  (mean_valid),
        .round_mode  (mode_pipe[power_pkg::mode_delay-1]),
        .power       (power),
        .power_valid (power_valid)
    );

endmodule

// File: sim/avg_power_tb.sv
`timescale 1ns/1ns

module avg_power_tb;

    localparam int    clk_period      = 8;
    localparam int    drive_delay     = 1;
    localparam int    reset_cycles    = 3;
    localparam int    drain_cycles    = 10;
    localparam int    watchdog_margin = 40;
    localparam string data_file       = "sim/avg_power_input.txt";

    logic                                                 clk;
    logic                                                 rst;
    logic [power_pkg::lanes*power_pkg::sample_width-1:0] samples;
    logic                                                 in_valid;
    logic                                                 round_mode;
    power_pkg::power_t                                    power;
    logic                                                 power_valid;

    // Stimulus in file order, one entry per driven cycle.
    logic                                                 stim_valid_q [$];
    logic                                                 stim_mode_q [$];
    logic [power_pkg::lanes*power_pkg::sample_width-1:0] stim_word_q [$];

    // Expected results in the order the DUT must produce them.
    power_pkg::power_t expected_q [$];

    int file_lines     = 0;
    bit file_loaded    = 1'b0;
    int words_sent     = 0;
    int mismatch_count = 0;
    int other_count    = 0;

    avg_power_top DUT (
        .clk         (clk),
        .rst         (rst),
        .samples     (samples),
        .in_valid    (in_valid),
        .round_mode  (round_mode),
        .power       (power),
        .power_valid (power_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ##############################
    // Data file and checks
    // ##############################

    task automatic load_stimulus();
        int    fd;
        int    fields;
        int    mode;
        int    expected;
        int    lane_val [power_pkg::lanes];
        string line;
        logic [power_pkg::lanes*power_pkg::sample_width-1:0] word;
        fd = $fopen(data_file, "r");
        if (fd == 0) begin
            $display("Error: the data file %s could not be opened", data_file);
            other_count++;
            file_loaded = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            file_lines++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            if (line[0] == "W") begin
                fields = $sscanf(line, "W %d %h %h %h %h %h %h %h %h", mode,
                                 lane_val[0], lane_val[1], lane_val[2], lane_val[3],
                                 lane_val[4], lane_val[5], lane_val[6], lane_val[7]);
                if (fields != 9) begin
                    $display("Error: line %0d of the data file is not a valid word",
                             file_lines);
                    other_count++;
                end else begin
                    for (int i = 0; i < power_pkg::lanes; i++) begin
                        word[power_pkg::sample_width*i +: power_pkg::sample_width] =
                            power_pkg::sample_t'(lane_val[i]);
                    end
                    stim_valid_q.push_back(1'b1);
                    stim_mode_q.push_back(mode != 0);
                    stim_word_q.push_back(word);
                end
            end else if (line[0] == "I") begin
                stim_valid_q.push_back(1'b0);
                stim_mode_q.push_back(1'b0);
                stim_word_q.push_back('0);
            end else if (line[0] == "E") begin
                fields = $sscanf(line, "E %d", expected);
                if (fields != 1) begin
                    $display("Error: line %0d of the data file has no expected value",
                             file_lines);
                    other_count++;
                end else begin
                    expected_q.push_back(power_pkg::power_t'(expected));
                end
            end else begin
                $display("Error: line %0d of the data file has an unknown command",
                         file_lines);
                other_count++;
            end
        end
        $fclose(fd);
        file_loaded = 1'b1;
    endtask

    task automatic check_power(input power_pkg::power_t got, input power_pkg::power_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: power is %0d, expected %0d", $time, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_idle(input logic got_valid);
        if (got_valid !== 1'b0) begin
            $display("Error at %0t ns: power_valid rose before the window was full", $time);
            other_count++;
        end
    endtask

    task automatic print_summary();
        $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
    endtask

    // ##############################
    // Stimulus, monitor, watchdog
    // ##############################

    initial begin
        rst        = 1'b1;
        samples    = '0;
        in_valid   = 1'b0;
        round_mode = 1'b0;
        load_stimulus();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        while (stim_valid_q.size() > 0) begin
            in_valid   = stim_valid_q.pop_front();
            round_mode = stim_mode_q.pop_front();
            samples    = stim_word_q.pop_front();
            if (in_valid) begin
                words_sent++;
            end
            @(posedge clk);
            #drive_delay;
        end
        in_valid = 1'b0;
        // Results still in the pipeline arrive within the DUT latency.
        while (expected_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (drain_cycles) @(posedge clk);
        #drive_delay;
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Outputs change on the rising edge, so they are read on the falling one.
    initial begin
        power_pkg::power_t expected_value;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (words_sent < average_pkg::window_len) begin
                    check_idle(power_valid);
                end else if (power_valid === 1'b1) begin
                    if (expected_q.size() == 0) begin
                        $display("Error at %0t ns: power_valid high with no result expected",
                                 $time);
                        other_count++;
                    end else begin
                        expected_value = expected_q.pop_front();
                        check_power(power, expected_value);
                    end
                end
            end
        end
    end

    initial begin
        wait (file_loaded);
        #((file_lines + watchdog_margin) * clk_period);
        $display("Error: timeout, %0d expected results never arrived", expected_q.size());
        other_count++;
        print_summary();
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sim/avg_power_input.txt
# W <round mode, 0 truncate, 1 nearest> <lane 0 .. lane 7, hex>; I is one idle cycle.
# E <expected power, decimal> belongs to the word on the line above it.
# Warm-up at full scale, only the 16th word gives a result.
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
I
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
W 0 ff ff ff ff ff ff ff ff
E 65025
# Full window in nearest mode.
W 1 ff ff ff ff ff ff ff ff
E 65025
# Step down to lane values 1 to 8, the window slides word by word.
W 1 01 02 03 04 05 06 07 08
E 60963
W 0 08 07 06 05 04 03 02 01
E 56900
I
W 0 03 01 04 02 07 05 08 06
E 52837
W 1 05 06 07 08 01 02 03 04
E 48775
W 1 02 04 06 08 01 03 05 07
E 44713
I
I
W 0 07 05 03 01 08 06 04 02
E 40650
W 0 04 03 02 01 08 07 06 05
E 36587
W 1 06 08 05 07 02 04 01 03
E 32525

// File: avg_power.f
rtl/power_pkg.sv
rtl/average_pkg.sv
rtl/square_lanes.sv
rtl/adder_tree.sv
rtl/moving_average.sv
rtl/power_normalize.sv
rtl/avg_power_top.sv
sim/avg_power_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the avg_power testbench with Verilator and runs it.
# The exit status is zero only when the log shows a clean run.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_binary=avg_power_sim
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module avg_power_tb \
    -f avg_power.f \
    --Mdir "$build_dir" \
    -o "$sim_binary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_binary" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log_file"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED, see $log_file"
    exit 1
fi
